//--- all.f
radio_ctrl_pkg.sv
setting_reg.sv
stream_fifo.sv
ctrl_packet_engine.sv
time_core_64.sv
gpio_atr.sv
radio_ctrl_core.sv
tb_clock_gen.sv
radio_ctrl_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the radio control core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
sim_out=""

verilator --binary --timing -f all.f --top-module radio_ctrl_core_tb \
   && sim_out="$(./obj_dir/Vradio_ctrl_core_tb 2>&1 || true)" \
   && printf '%s\n' "$sim_out" \
   && grep -q '^Testbench passed$' <<< "$sim_out" \
   && echo "Simulation result: PASS" && exit 0 \
   || { echo "Simulation result: FAIL"; exit 1; }

//--- radio_ctrl_core_tb.sv
// Directed-test testbench for the radio control core
module radio_ctrl_core_tb
   import radio_ctrl_pkg::*;
();

   localparam int          MAX_REQUESTS   = 40;
   localparam int          CYCLES_PER_REQ = 20;
   localparam int          WAIT_LIMIT     = 50;
   localparam logic [31:0] LFSR_SEED      = 32'h2932_ba77;
   localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

   logic                  clk;
   logic                  por_rst_n;
   logic                  tb_rst_n;
   logic                  rst_n;
   stream_word_t          ctrl_data;
   logic                  ctrl_src_rdy;
   logic                  ctrl_dst_rdy;
   stream_word_t          resp_data;
   logic                  resp_src_rdy;
   logic                  resp_dst_rdy;
   logic                  pps;
   logic                  clock_sync;
   logic                  run_rx;
   logic                  run_tx;
   logic [GPIO_WIDTH-1:0] gpio_in;
   logic [GPIO_WIDTH-1:0] gpio_out;
   logic [GPIO_WIDTH-1:0] gpio_oe;
   logic [31:0]           lfsr_q;
   logic [7:0]            seq_q;
   logic [31:0]           config0_val;
   logic [31:0]           config1_val;

   // Power-on reset combined with the pulse of the persistence test
   assign rst_n = por_rst_n && tb_rst_n;

   tb_clock_gen clock_gen_i (.clk_o (clk), .rst_n_o (por_rst_n));

   radio_ctrl_core radio_ctrl_core_i (
      .clk_i (clk), .rst_n_i (rst_n),
      .ctrl_data_i (ctrl_data), .ctrl_src_rdy_i (ctrl_src_rdy), .ctrl_dst_rdy_o (ctrl_dst_rdy),
      .resp_data_o (resp_data), .resp_src_rdy_o (resp_src_rdy), .resp_dst_rdy_i (resp_dst_rdy),
      .pps_i (pps), .clock_sync_o (clock_sync), .run_rx_i (run_rx), .run_tx_i (run_tx),
      .gpio_i (gpio_in), .gpio_o (gpio_out), .gpio_oe_o (gpio_oe)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Checking and random data
   ////////////////////////////////////////////////////////////////////////////
   task automatic stop_with_failure();
      $display("Testbench failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("ERROR at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
                  expected);
         stop_with_failure();
      end
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ LFSR_TAPS;
      end
      return next;
   endfunction

   // One LFSR step per bit, shifted in at the low end
   task automatic random_word(input int bits, output logic [31:0] word);
      int i;
      word = '0;
      for (i = 0; i < bits; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         word   = {word[30:0], lfsr_q[0]};
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stream access
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] make_cmd(input logic [7:0] seq, input logic [3:0] rb_sel,
                                            input logic wr, input logic [7:0] addr);
      ctrl_cmd_u cmd;
      cmd.raw          = '0;
      cmd.cmd.seq      = seq;
      cmd.cmd.rb_sel   = rb_sel;
      cmd.cmd.wr       = wr;
      cmd.cmd.set_addr = addr;
      return cmd.raw;
   endfunction

   task automatic send_word(input logic is_sof, input logic is_eof, input logic [31:0] payload);
      int cycles;
      cycles = 0;
      @(posedge clk);
      ctrl_data    <= '{sof: is_sof, eof: is_eof, occ: 2'b00, data: payload};
      ctrl_src_rdy <= 1'b1;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            $display("Timeout: the control FIFO never accepted a request word");
            stop_with_failure();
         end
      end while (!ctrl_dst_rdy);
      ctrl_src_rdy <= 1'b0;
   endtask

   task automatic send_request(input logic [31:0] cmd, input logic [31:0] payload);
      send_word(1'b1, 1'b0, cmd);
      send_word(1'b0, 1'b1, payload);
   endtask

   task automatic get_reply(output logic [31:0] header, output logic [31:0] value);
      int cycles;
      int words;
      cycles = 0;
      words  = 0;
      @(posedge clk);
      resp_dst_rdy <= 1'b1;
      while (words < 2) begin
         @(posedge clk);
         cycles++;
         if (resp_src_rdy) begin
            // Flags are sof, eof and the two occ bits
            if (words == 0) begin
               check_value("resp_data_o header flags",
                           64'({resp_data.sof, resp_data.eof, resp_data.occ}), 64'(4'b1000));
               header = resp_data.data;
            end else begin
               check_value("resp_data_o value flags",
                           64'({resp_data.sof, resp_data.eof, resp_data.occ}), 64'(4'b0100));
               value = resp_data.data;
            end
            words++;
         end else if (cycles > WAIT_LIMIT) begin
            $display("Timeout: no complete reply arrived on the response stream");
            stop_with_failure();
         end
      end
      resp_dst_rdy <= 1'b0;
   endtask

   task automatic transact(input logic [3:0] rb_sel, input logic wr, input logic [7:0] addr,
                           input logic [31:0] payload, output logic [31:0] value);
      logic [31:0] cmd;
      logic [31:0] header;
      cmd   = make_cmd(seq_q, rb_sel, wr, addr);
      seq_q = seq_q + 8'd1;
      send_request(cmd, payload);
      get_reply(header, value);
      check_value("reply header", 64'(header), 64'(cmd));
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] payload);
      logic [31:0] unused;
      transact(RB_COMPAT, 1'b1, addr, payload, unused);
   endtask

   task automatic read_rb(input logic [3:0] rb_sel, output logic [31:0] value);
      transact(rb_sel, 1'b0, 8'd0, 32'h0, value);
   endtask

   task automatic drive_pps(input logic level);
      @(posedge clk);
      pps <= level;
   endtask

   task automatic wait_gpio(input logic [GPIO_WIDTH-1:0] expected);
      int i;
      for (i = 0; i < 3; i++) begin
         @(posedge clk);
         if (gpio_out == expected) begin
            break;
         end
      end
      check_value("gpio_o", 64'(gpio_out), 64'(expected));
   endtask

   task automatic wait_clock_sync(input logic expected);
      int i;
      for (i = 0; i < 3; i++) begin
         @(posedge clk);
         if (clock_sync == expected) begin
            break;
         end
      end
      check_value("clock_sync_o", 64'(clock_sync), 64'(expected));
   endtask

   task automatic pulse_reset();
      @(posedge clk);
      tb_rst_n <= 1'b0;
      repeat (4) @(posedge clk);
      check_value("ctrl_dst_rdy_o in reset", 64'(ctrl_dst_rdy), 64'd0);
      tb_rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      check_value("ctrl_dst_rdy_o after reset", 64'(ctrl_dst_rdy), 64'd1);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////
   task automatic readback_echo_test();
      logic [3:0]  sels [3];
      logic [31:0] value;
      int          i;
      sels = '{4'd8, 4'd12, 4'd15};
      read_rb(RB_COMPAT, value);
      check_value("RB_COMPAT", 64'(value), 64'(COMPAT_NUM));
      for (i = 0; i < 3; i++) begin
         read_rb(sels[i], value);
         check_value("unmapped readback", 64'(value), 64'(32'hffff_ffff));
      end
   endtask

   task automatic config_persist_test();
      logic [31:0] value;
      logic [15:0] ddr;
      random_word(32, config0_val);
      random_word(32, config1_val);
      // Read in the same packet already sees the write
      transact(RB_CONFIG0, 1'b1, SR_CONFIG0, config0_val, value);
      check_value("RB_CONFIG0", 64'(value), 64'(config0_val));
      transact(RB_CONFIG1, 1'b1, SR_CONFIG1, config1_val, value);
      check_value("RB_CONFIG1", 64'(value), 64'(config1_val));
      // Non-zero state that the reset must clear
      write_reg(SR_CLOCK_SYNC, 32'h3);
      random_word(16, value);
      ddr = value[15:0] | 16'h0001;
      write_reg(SR_GPIO_DDR, {16'h0, ddr});
      check_value("clock_sync_o", 64'(clock_sync), 64'd1);
      check_value("gpio_oe_o", 64'(gpio_oe), 64'(ddr));
      pulse_reset();
      check_value("clock_sync_o", 64'(clock_sync), 64'd0);
      check_value("gpio_oe_o", 64'(gpio_oe), 64'd0);
      read_rb(RB_CONFIG0, value);
      check_value("RB_CONFIG0 after reset", 64'(value), 64'(config0_val));
      read_rb(RB_CONFIG1, value);
      check_value("RB_CONFIG1 after reset", 64'(value), 64'(config1_val));
   endtask

   task automatic gpio_atr_test();
      logic [31:0] rnd;
      logic [15:0] words [4];
      logic [15:0] ddr;
      logic [15:0] pins;
      int          i;
      random_word(16, rnd);
      ddr = rnd[15:0];
      write_reg(SR_GPIO_DDR, {16'h0, ddr});
      // Idle, rx, tx and fdx sit at consecutive addresses
      for (i = 0; i < 4; i++) begin
         random_word(16, rnd);
         words[i] = rnd[15:0];
         write_reg(SR_GPIO_IDLE + 8'(i), {16'h0, words[i]});
      end
      for (i = 0; i < 4; i++) begin
         @(posedge clk);
         run_rx <= i[0];
         run_tx <= i[1];
         wait_gpio(words[i]);
         check_value("gpio_oe_o", 64'(gpio_oe), 64'(ddr));
      end
      random_word(16, rnd);
      pins = rnd[15:0];
      @(posedge clk);
      gpio_in <= pins;
      read_rb(RB_GPIO, rnd);
      check_value("RB_GPIO", 64'(rnd), 64'({16'h0, pins}));
   endtask

   task automatic time_core_test();
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] value;
      write_reg(SR_TIME_CTRL, 32'h0);
      random_word(32, hi);
      // Below 2^31 so the low word cannot carry into the high word
      random_word(31, lo);
      write_reg(SR_TIME_HI, hi);
      transact(RB_TIME_HI, 1'b1, SR_TIME_LO, lo, value);
      check_value("RB_TIME_HI", 64'(value), 64'(hi));
      read_rb(RB_TIME_LO, value);
      if (value - lo > 32'd20) begin
         check_value("RB_TIME_LO", 64'(value), 64'(lo));
      end
      // Load deferred to the next pps edge
      write_reg(SR_TIME_CTRL, 32'h1);
      random_word(32, hi);
      random_word(31, lo);
      write_reg(SR_TIME_HI, hi);
      write_reg(SR_TIME_LO, lo);
      drive_pps(1'b1);
      repeat (4) @(posedge clk);
      pps <= 1'b0;
      read_rb(RB_PPS_HI, value);
      check_value("RB_PPS_HI", 64'(value), 64'(hi));
      read_rb(RB_PPS_LO, value);
      if (value - lo > 32'd4) begin
         check_value("RB_PPS_LO", 64'(value), 64'(lo));
      end
      read_rb(RB_TIME_HI, value);
      check_value("RB_TIME_HI after pps", 64'(value), 64'(hi));
      write_reg(SR_TIME_CTRL, 32'h0);
   endtask

   task automatic clock_sync_test();
      int i;
      write_reg(SR_CLOCK_SYNC, 32'h1);
      drive_pps(1'b1);
      wait_clock_sync(1'b1);
      drive_pps(1'b0);
      wait_clock_sync(1'b0);
      // Inverted
      write_reg(SR_CLOCK_SYNC, 32'h3);
      wait_clock_sync(1'b1);
      drive_pps(1'b1);
      wait_clock_sync(1'b0);
      drive_pps(1'b0);
      wait_clock_sync(1'b1);
      write_reg(SR_CLOCK_SYNC, 32'h0);
      for (i = 0; i < 8; i++) begin
         @(posedge clk);
         pps <= i[1];
         check_value("clock_sync_o disabled", 64'(clock_sync), 64'd0);
      end
      drive_pps(1'b0);
   endtask

   task automatic backpressure_test();
      logic [3:0]  sels [4];
      logic [31:0] expected [4];
      logic [31:0] cmds [4];
      logic [31:0] header;
      logic [31:0] value;
      int          i;
      sels     = '{RB_CONFIG0, RB_CONFIG1, RB_COMPAT, 4'd9};
      expected = '{config0_val, config1_val, COMPAT_NUM, 32'hffff_ffff};
      for (i = 0; i < 4; i++) begin
         cmds[i] = make_cmd(8'hc0 + 8'(i), sels[i], 1'b0, 8'd0);
         send_request(cmds[i], 32'h0);
      end
      // Replies pile up in the response FIFO
      repeat (10) @(posedge clk);
      check_value("ctrl_dst_rdy_o", 64'(ctrl_dst_rdy), 64'd1);
      check_value("resp_src_rdy_o", 64'(resp_src_rdy), 64'd1);
      for (i = 0; i < 4; i++) begin
         get_reply(header, value);
         check_value("queued reply header", 64'(header), 64'(cmds[i]));
         check_value("queued reply value", 64'(value), 64'(expected[i]));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      lfsr_q       = LFSR_SEED;
      seq_q        = 8'h01;
      tb_rst_n     <= 1'b1;
      ctrl_data    <= '0;
      ctrl_src_rdy <= 1'b0;
      resp_dst_rdy <= 1'b0;
      pps          <= 1'b0;
      run_rx       <= 1'b0;
      run_tx       <= 1'b0;
      gpio_in      <= '0;
      wait (por_rst_n === 1'b1);
      repeat (2) @(posedge clk);
      readback_echo_test();
      config_persist_test();
      gpio_atr_test();
      time_core_test();
      clock_sync_test();
      backpressure_test();
      $display("Testbench passed");
      $finish;
   end

   initial begin
      repeat (MAX_REQUESTS * CYCLES_PER_REQ) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles",
               MAX_REQUESTS * CYCLES_PER_REQ);
      stop_with_failure();
   end

endmodule

//--- tb_clock_gen.sv
// Testbench clock and power-on reset generator
module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   localparam int HALF_PERIOD  = 50;
   localparam int RESET_CYCLES = 4;

   initial begin
      clk_o = 1'b0;
      forever begin
         #HALF_PERIOD clk_o = ~clk_o;
      end
   end

   // Released on a rising edge
   initial begin
      rst_n_o <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

//--- radio_ctrl_core.sv
// Radio control core: control FIFOs, packet engine, misc registers, time core and GPIO
module radio_ctrl_core
   import radio_ctrl_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  stream_word_t          ctrl_data_i,
   input  logic                  ctrl_src_rdy_i,
   output logic                  ctrl_dst_rdy_o,
   output stream_word_t          resp_data_o,
   output logic                  resp_src_rdy_o,
   input  logic                  resp_dst_rdy_i,
   input  logic                  pps_i,
   output logic                  clock_sync_o,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic [GPIO_WIDTH-1:0] gpio_i,
   output logic [GPIO_WIDTH-1:0] gpio_o,
   output logic [GPIO_WIDTH-1:0] gpio_oe_o
);

   stream_word_t ctrl_int_data;
   logic         ctrl_int_src_rdy;
   logic         ctrl_int_dst_rdy;
   stream_word_t resp_int_data;
   logic         resp_int_src_rdy;
   logic         resp_int_dst_rdy;
   set_bus_t     set_bus;
   logic [31:0]  config_word0;
   logic [31:0]  config_word1;
   logic [31:0]  gpio_readback;
   logic [63:0]  vita_time;
   logic [63:0]  vita_time_pps;

   ////////////////////////////////////////////////////////////////////////////
   // Control packets in, replies out
   ////////////////////////////////////////////////////////////////////////////
   stream_fifo ctrl_fifo (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .in_data_i (ctrl_data_i), .in_src_rdy_i (ctrl_src_rdy_i), .in_dst_rdy_o (ctrl_dst_rdy_o),
      .out_data_o (ctrl_int_data), .out_src_rdy_o (ctrl_int_src_rdy),
      .out_dst_rdy_i (ctrl_int_dst_rdy)
   );

   ctrl_packet_engine ctrl_packet_engine_i (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .in_data_i (ctrl_int_data), .in_src_rdy_i (ctrl_int_src_rdy),
      .in_dst_rdy_o (ctrl_int_dst_rdy),
      .out_data_o (resp_int_data), .out_src_rdy_o (resp_int_src_rdy),
      .out_dst_rdy_i (resp_int_dst_rdy),
      .set_bus_o (set_bus), .config0_i (config_word0), .config1_i (config_word1),
      .gpio_rb_i (gpio_readback), .time_i (vita_time), .time_pps_i (vita_time_pps)
   );

   stream_fifo resp_fifo (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .in_data_i (resp_int_data), .in_src_rdy_i (resp_int_src_rdy),
      .in_dst_rdy_o (resp_int_dst_rdy),
      .out_data_o (resp_data_o), .out_src_rdy_o (resp_src_rdy_o), .out_dst_rdy_i (resp_dst_rdy_i)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus clients
   ////////////////////////////////////////////////////////////////////////////
   // Config words survive a reset
   setting_reg #(.ADDR(SR_CONFIG0), .WIDTH(32), .HAS_RESET(1'b0)) sr_misc_config0 (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .set_bus_i (set_bus), .value_o (config_word0)
   );

   setting_reg #(.ADDR(SR_CONFIG1), .WIDTH(32), .HAS_RESET(1'b0)) sr_misc_config1 (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .set_bus_i (set_bus), .value_o (config_word1)
   );

   time_core_64 time_core_64_i (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .set_bus_i (set_bus), .pps_i (pps_i),
      .time_o (vita_time), .time_pps_o (vita_time_pps), .clock_sync_o (clock_sync_o)
   );

   gpio_atr gpio_atr_i (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .set_bus_i (set_bus),
      .run_rx_i (run_rx_i), .run_tx_i (run_tx_i), .gpio_i (gpio_i),
      .gpio_o (gpio_o), .gpio_oe_o (gpio_oe_o), .gpio_rb_o (gpio_readback)
   );

endmodule

//--- gpio_atr.sv
// ATR GPIO: outputs follow the radio run state, with direction and input readback
module gpio_atr
   import radio_ctrl_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  set_bus_t              set_bus_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic [GPIO_WIDTH-1:0] gpio_i,
   output logic [GPIO_WIDTH-1:0] gpio_o,
   output logic [GPIO_WIDTH-1:0] gpio_oe_o,
   output logic [31:0]           gpio_rb_o
);

   logic [GPIO_WIDTH-1:0] idle_word;
   logic [GPIO_WIDTH-1:0] rx_word;
   logic [GPIO_WIDTH-1:0] tx_word;
   logic [GPIO_WIDTH-1:0] fdx_word;
   logic [GPIO_WIDTH-1:0] gpio_meta_q;
   logic [GPIO_WIDTH-1:0] gpio_sync_q;

   setting_reg #(.ADDR(SR_GPIO_IDLE), .WIDTH(GPIO_WIDTH), .HAS_RESET(1'b1)) idle_reg (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .set_bus_i (set_bus_i), .value_o (idle_word)
   );

   setting_reg #(.ADDR(SR_GPIO_RX), .WIDTH(GPIO_WIDTH), .HAS_RESET(1'b1)) rx_reg (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .set_bus_i (set_bus_i), .value_o (rx_word)
   );

   setting_reg #(.ADDR(SR_GPIO_TX), .WIDTH(GPIO_WIDTH), .HAS_RESET(1'b1)) tx_reg (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .set_bus_i (set_bus_i), .value_o (tx_word)
   );

   setting_reg #(.ADDR(SR_GPIO_FDX), .WIDTH(GPIO_WIDTH), .HAS_RESET(1'b1)) fdx_reg (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .set_bus_i (set_bus_i), .value_o (fdx_word)
   );

   // Direction, a set bit drives the pin
   setting_reg #(.ADDR(SR_GPIO_DDR), .WIDTH(GPIO_WIDTH), .HAS_RESET(1'b1)) ddr_reg (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .set_bus_i (set_bus_i), .value_o (gpio_oe_o)
   );

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gpio_o      <= '0;
         gpio_meta_q <= '0;
         gpio_sync_q <= '0;
      end else begin
         case ({run_tx_i, run_rx_i})
            2'b00:   gpio_o <= idle_word;
            2'b01:   gpio_o <= rx_word;
            2'b10:   gpio_o <= tx_word;
            default: gpio_o <= fdx_word;
         endcase
         // Pins are asynchronous to clk_i
         gpio_meta_q <= gpio_i;
         gpio_sync_q <= gpio_meta_q;
      end
   end

   assign gpio_rb_o = {{(32 - GPIO_WIDTH){1'b0}}, gpio_sync_q};

endmodule

//--- time_core_64.sv
// 64-bit time counter with immediate or pps-aligned load, pps latch and clock sync
module time_core_64
   import radio_ctrl_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  set_bus_t    set_bus_i,
   input  logic        pps_i,
   output logic [63:0] time_o,
   output logic [63:0] time_pps_o,
   output logic        clock_sync_o
);

   logic [31:0] time_hi_buf;
   logic        load_at_pps;
   logic        sync_enb;
   logic        sync_inv;
   logic        pps_meta_q;
   logic        pps_sync_q;
   logic        pps_dly_q;
   logic        pps_edge;
   logic        set_lo;
   logic        pending_q;
   logic [63:0] pending_time_q;
   logic [63:0] time_d;

   setting_reg #(.ADDR(SR_TIME_HI), .WIDTH(32), .HAS_RESET(1'b1)) time_hi_reg (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .set_bus_i (set_bus_i),
      .value_o   (time_hi_buf)
   );

   // Bit 0 defers the load to the next pps edge
   setting_reg #(.ADDR(SR_TIME_CTRL), .WIDTH(1), .HAS_RESET(1'b1)) time_ctrl_reg (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .set_bus_i (set_bus_i),
      .value_o   (load_at_pps)
   );

   setting_reg #(.ADDR(SR_CLOCK_SYNC), .WIDTH(2), .HAS_RESET(1'b1)) clock_sync_reg (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .set_bus_i (set_bus_i),
      .value_o   ({sync_inv, sync_enb})
   );

   assign set_lo   = set_bus_i.stb && (set_bus_i.addr == SR_TIME_LO);
   assign pps_edge = pps_sync_q && !pps_dly_q;

   always_comb begin
      time_d = time_o + 64'd1;
      if (set_lo && !load_at_pps) begin
         time_d = {time_hi_buf, set_bus_i.data};
      end else if (pps_edge && pending_q) begin
         time_d = pending_time_q;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pps_meta_q <= 1'b0;
         pps_sync_q <= 1'b0;
         pps_dly_q  <= 1'b0;
         pending_q  <= 1'b0;
         time_o     <= '0;
         time_pps_o <= '0;
      end else begin
         pps_meta_q <= pps_i;
         pps_sync_q <= pps_meta_q;
         pps_dly_q  <= pps_sync_q;
         time_o     <= time_d;
         if (set_lo && load_at_pps) begin
            pending_q <= 1'b1;
         end else if (pps_edge) begin
            pending_q <= 1'b0;
         end
         // Latch what the counter takes on at this edge
         if (pps_edge) begin
            time_pps_o <= time_d;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (set_lo && load_at_pps) begin
         pending_time_q <= {time_hi_buf, set_bus_i.data};
      end
   end

   assign clock_sync_o = sync_enb && (pps_sync_q ^ sync_inv);

endmodule

//--- ctrl_packet_engine.sv
// Control packet engine: settings writes, readback select and two-word replies
module ctrl_packet_engine
   import radio_ctrl_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  stream_word_t in_data_i,
   input  logic         in_src_rdy_i,
   output logic         in_dst_rdy_o,
   output stream_word_t out_data_o,
   output logic         out_src_rdy_o,
   input  logic         out_dst_rdy_i,
   output set_bus_t     set_bus_o,
   input  logic [31:0]  config0_i,
   input  logic [31:0]  config1_i,
   input  logic [31:0]  gpio_rb_i,
   input  logic [63:0]  time_i,
   input  logic [63:0]  time_pps_i
);

   enum logic [2:0] {
      S_HDR,
      S_DATA,
      S_WRITE,
      S_RB,
      S_RPL_HDR,
      S_RPL_DATA
   } state_q;

   ctrl_cmd_u   cmd_q;
   logic [31:0] rb_q;
   logic [31:0] rb_word;
   logic        set_stb_q;
   logic [7:0]  set_addr_q;
   logic [31:0] set_data_q;
   logic        in_fire;
   logic        hdr_fire;
   logic        data_fire;

   ////////////////////////////////////////////////////////////////////////////
   // Request side
   ////////////////////////////////////////////////////////////////////////////
   assign in_dst_rdy_o = (state_q == S_HDR) || (state_q == S_DATA);
   assign in_fire      = in_src_rdy_i && in_dst_rdy_o;
   // Words without sof are dropped while waiting for a header
   assign hdr_fire     = in_fire && (state_q == S_HDR) && in_data_i.sof;
   assign data_fire    = in_fire && (state_q == S_DATA);

   assign set_bus_o = '{stb: set_stb_q, addr: set_addr_q, data: set_data_q};

   // Readback mux
   always_comb begin
      case (cmd_q.cmd.rb_sel)
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_CONFIG0: rb_word = config0_i;
         RB_CONFIG1: rb_word = config1_i;
         RB_GPIO:    rb_word = gpio_rb_i;
         RB_TIME_HI: rb_word = time_i[63:32];
         RB_TIME_LO: rb_word = time_i[31:0];
         RB_PPS_HI:  rb_word = time_pps_i[63:32];
         RB_PPS_LO:  rb_word = time_pps_i[31:0];
         default:    rb_word = '1;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= S_HDR;
         set_stb_q <= 1'b0;
      end else begin
         set_stb_q <= 1'b0;
         case (state_q)
            S_HDR: begin
               if (hdr_fire) begin
                  state_q <= S_DATA;
               end
            end
            S_DATA: begin
               if (data_fire) begin
                  state_q   <= S_WRITE;
                  set_stb_q <= cmd_q.cmd.wr;
               end
            end
            // Strobe is on the bus this cycle
            S_WRITE: state_q <= S_RB;
            // Written register is visible now
            S_RB: state_q <= S_RPL_HDR;
            S_RPL_HDR: begin
               if (out_dst_rdy_i) begin
                  state_q <= S_RPL_DATA;
               end
            end
            S_RPL_DATA: begin
               if (out_dst_rdy_i) begin
                  state_q <= S_HDR;
               end
            end
            default: state_q <= S_HDR;
         endcase
      end
   end

   // Command, write payload and readback word
   always_ff @(posedge clk_i) begin
      if (hdr_fire) begin
         cmd_q.raw <= in_data_i.data;
      end
      if (data_fire) begin
         set_addr_q <= cmd_q.cmd.set_addr;
         set_data_q <= in_data_i.data;
      end
      if (state_q == S_RB) begin
         rb_q <= rb_word;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reply side
   ////////////////////////////////////////////////////////////////////////////
   assign out_src_rdy_o = (state_q == S_RPL_HDR) || (state_q == S_RPL_DATA);

   always_comb begin
      out_data_o      = '0;
      out_data_o.sof  = (state_q == S_RPL_HDR);
      out_data_o.eof  = (state_q == S_RPL_DATA);
      // Header echoes the command word untouched
      out_data_o.data = (state_q == S_RPL_HDR) ? cmd_q.raw : rb_q;
   end

endmodule

//--- stream_fifo.sv
// Circular-buffer FIFO for 36-bit stream words with src_rdy/dst_rdy on both sides
module stream_fifo
   import radio_ctrl_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  stream_word_t in_data_i,
   input  logic         in_src_rdy_i,
   output logic         in_dst_rdy_o,
   output stream_word_t out_data_o,
   output logic         out_src_rdy_o,
   input  logic         out_dst_rdy_i
);

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   stream_word_t               mem [DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr_q;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_q;
   logic [FIFO_DEPTH_LOG2:0]   count_q;
   logic [FIFO_DEPTH_LOG2:0]   count_d;
   logic                       not_full_q;
   logic                       do_wr;
   logic                       do_rd;

   assign do_wr = in_src_rdy_i && not_full_q;
   assign do_rd = out_src_rdy_o && out_dst_rdy_i;

   assign in_dst_rdy_o  = not_full_q;
   assign out_src_rdy_o = (count_q != '0);
   assign out_data_o    = mem[rd_ptr_q];

   always_comb begin
      count_d = count_q;
      if (do_wr && !do_rd) begin
         count_d = count_q + 1'b1;
      end else if (do_rd && !do_wr) begin
         count_d = count_q - 1'b1;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         not_full_q <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_rd) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         count_q    <= count_d;
         not_full_q <= (count_d != DEPTH[FIFO_DEPTH_LOG2:0]);
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wr_ptr_q] <= in_data_i;
      end
   end

endmodule

//--- setting_reg.sv
// Single settings bus register, loaded on a strobe to its own address
module setting_reg
   import radio_ctrl_pkg::*;
#(
   parameter logic [7:0] ADDR      = 8'd0,
   parameter int         WIDTH     = 32,
   parameter bit         HAS_RESET = 1'b1
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  set_bus_t         set_bus_i,
   output logic [WIDTH-1:0] value_o
);

   logic load;

   assign load = set_bus_i.stb && (set_bus_i.addr == ADDR);

   generate
      if (HAS_RESET) begin : g_rst
         always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
               value_o <= '0;
            end else if (load) begin
               value_o <= set_bus_i.data[WIDTH-1:0];
            end
         end
      end else begin : g_no_rst
         // Keeps its contents through a reset
         always_ff @(posedge clk_i) begin
            if (load) begin
               value_o <= set_bus_i.data[WIDTH-1:0];
            end
         end
      end
   endgenerate

endmodule

//--- radio_ctrl_pkg.sv
// Shared types, register map and constants for the radio control path
package radio_ctrl_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Sizes and constants
   ////////////////////////////////////////////////////////////////////////////
   localparam int GPIO_WIDTH      = 16;
   localparam int FIFO_DEPTH_LOG2 = 3;

   // Major in the upper half, minor in the lower half
   localparam logic [31:0] COMPAT_NUM = {16'd12, 16'd1};

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus addresses
   ////////////////////////////////////////////////////////////////////////////
   localparam logic [7:0] SR_CONFIG0    = 8'd0;
   localparam logic [7:0] SR_CONFIG1    = 8'd1;
   localparam logic [7:0] SR_CLOCK_SYNC = 8'd2;
   localparam logic [7:0] SR_TIME_HI    = 8'd8;
   localparam logic [7:0] SR_TIME_LO    = 8'd9;
   localparam logic [7:0] SR_TIME_CTRL  = 8'd10;
   localparam logic [7:0] SR_GPIO_IDLE  = 8'd16;
   localparam logic [7:0] SR_GPIO_RX    = 8'd17;
   localparam logic [7:0] SR_GPIO_TX    = 8'd18;
   localparam logic [7:0] SR_GPIO_FDX   = 8'd19;
   localparam logic [7:0] SR_GPIO_DDR   = 8'd20;

   // Readback selectors, anything not listed reads all ones
   localparam logic [3:0] RB_COMPAT  = 4'd0;
   localparam logic [3:0] RB_CONFIG0 = 4'd1;
   localparam logic [3:0] RB_CONFIG1 = 4'd2;
   localparam logic [3:0] RB_GPIO    = 4'd3;
   localparam logic [3:0] RB_TIME_HI = 4'd4;
   localparam logic [3:0] RB_TIME_LO = 4'd5;
   localparam logic [3:0] RB_PPS_HI  = 4'd6;
   localparam logic [3:0] RB_PPS_LO  = 4'd7;

   // 36-bit stream word, qualified by src_rdy/dst_rdy
   typedef struct packed {
      logic        sof;
      logic        eof;
      logic [1:0]  occ;
      logic [31:0] data;
   } stream_word_t;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Command word of a control packet
   typedef struct packed {
      logic [7:0] seq;
      logic [3:0] rsvd_hi;
      logic [3:0] rb_sel;
      logic [6:0] rsvd_lo;
      logic       wr;
      logic [7:0] set_addr;
   } ctrl_cmd_t;

   typedef union packed {
      ctrl_cmd_t   cmd;
      logic [31:0] raw;
   } ctrl_cmd_u;

endpackage
